// ==== rename_top.f ====
hdl/isa_pkg.sv
hdl/rob_pkg.sv
hdl/reg_status.sv
hdl/reorder_buffer.sv
hdl/arch_regfile.sv
hdl/operand_select.sv
hdl/rename_top.sv
test/tb_rename_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the rename stage testbench with Verilator, from the project root
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --top-module tb_rename_top -f rename_top.f -o tb_rename_top > "$LOG" 2>&1 \
    && ./obj_dir/tb_rename_top >> "$LOG" 2>&1 \
    || { cat "$LOG"; echo "Build or simulation did not complete"; exit 1; }

cat "$LOG"
grep -q "Something failed" "$LOG" && exit 1 || exit 0

// ==== test/rename_stim.txt ====
// cmd a b c d e f g h  1 reset, 5 idle: a=ready b=commit c=idx  3 wb: a=tag b=data  4 commit: a=rd b=data
// 2 issue, 7 blocked issue: a=rd b=rs1 c=rs2 d=idx e/f g/h=rs1 rs2 ready+value|tag  6 flush  0 end
1 1 0 0 0 0 0 0 0
2 5 1 2 0 1 0 1 0
2 6 5 0 1 0 0 1 0
2 7 6 5 2 0 1 0 0
3 1 11111111 0 0 0 0 0 0
5 1 0 3 0 0 0 0 0
2 8 6 7 3 1 11111111 0 2
3 3 33333333 0 0 0 0 0 0
3 2 22222222 0 0 0 0 0 0
5 1 0 4 0 0 0 0 0
3 0 0000a5a5 0 0 0 0 0 0
4 5 0000a5a5 0 0 0 0 0 0
4 6 11111111 0 0 0 0 0 0
4 7 22222222 0 0 0 0 0 0
4 8 33333333 0 0 0 0 0 0
2 9 5 8 4 1 0000a5a5 1 33333333
2 a 0 0 5 1 0 1 0
2 a 9 a 6 0 4 0 5
2 b a 1 7 0 6 1 0
3 5 55555555 0 0 0 0 0 0
3 4 44444444 0 0 0 0 0 0
4 9 44444444 0 0 0 0 0 0
4 a 55555555 0 0 0 0 0 0
2 c a 9 0 0 6 1 44444444
3 6 66666666 0 0 0 0 0 0
4 a 66666666 0 0 0 0 0 0
2 d a b 1 1 66666666 0 7
2 e d c 2 0 1 0 0
2 f 0 1 3 1 0 1 0
2 10 0 0 4 1 0 1 0
2 11 0 0 5 1 0 1 0
2 12 0 0 6 1 0 1 0
7 13 0 0 0 0 0 0 0
5 0 0 7 0 0 0 0 0
6 0 0 0 0 0 0 0 0
2 14 a 5 0 1 66666666 1 0000a5a5
2 15 d 9 1 1 0 1 44444444
0 0 0 0 0 0 0 0 0

// ==== test/tb_rename_top.sv ====
// Testbench for the register status and reorder stage
// Replays the commands of test/rename_stim.txt (reset, issue, writeback, commit,
// idle, flush, blocked issue) and compares the DUT ports with the expected columns
// Run from the project root so the stimulus path resolves

`timescale 1ns/1ns
`default_nettype none

module tb_rename_top;

    localparam int COLS       = 9;    // Words per command line
    localparam int MAX_CMDS   = 64;
    localparam int WAIT_LIMIT = 20;   // Cycles before a wait gives up

    logic                clk_i;
    logic                rst_n_i;
    logic                flush_i;
    logic                issue_valid_i;
    isa_pkg::issue_req_t issue_req_i;
    logic                issue_ready_o;
    rob_pkg::rob_idx_t   issue_rob_idx_o;
    rob_pkg::operand_t   rs1_op_o;
    rob_pkg::operand_t   rs2_op_o;
    logic                wb_valid_i;
    rob_pkg::wb_t        wb_i;
    logic                commit_valid_o;
    isa_pkg::commit_t    commit_o;

    logic [31:0] stim_mem [COLS*MAX_CMDS];   // Flat, command n starts at n*COLS
    int          checks;
    int          mismatches;
    int          aborts;                     // Timeouts and bad command codes
    int          cmd_no;

    rename_top i_rename_top (.*);

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;   // 4 ns period
    end

    // Step to 1 ns after the next rising edge, inputs back to idle
    task automatic next_cycle();
        @(posedge clk_i);
        #1;
        issue_valid_i = 1'b0;
        wb_valid_i    = 1'b0;
        flush_i       = 1'b0;
    endtask

    task automatic apply_reset();
        rst_n_i = 1'b0;
        repeat (4) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;
    endtask

    task automatic check_equal(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        checks++;
        if (got !== expected) begin
            mismatches++;
            $display("Fail at %0t ns: command %0d, %s is %h, expected %h",
                     $time, cmd_no, what, got, expected);
        end
    endtask

    // Ready operands are judged by value, waiting ones by tag
    task automatic check_operand(input string what, input rob_pkg::operand_t op,
                                 input logic [31:0] exp_ready, input logic [31:0] exp_word);
        check_equal({what, " ready"}, 32'(op.ready), exp_ready);
        if (exp_ready != 0) begin
            check_equal({what, " value"}, op.value, exp_word);
        end else begin
            check_equal({what, " tag"}, 32'(op.tag), exp_word);
        end
    endtask

    task automatic check_status(input int b);
        check_equal("issue_ready_o", 32'(issue_ready_o), stim_mem[b+1]);
        check_equal("commit_valid_o", 32'(commit_valid_o), stim_mem[b+2]);
        check_equal("issue_rob_idx_o", 32'(issue_rob_idx_o), stim_mem[b+3]);
    endtask

    task automatic report_timeout(input string what);
        aborts++;
        $display("Timeout at %0t ns: command %0d waited %0d cycles for %s",
                 $time, cmd_no, WAIT_LIMIT, what);
    endtask

    task automatic drive_request(input int b);
        issue_valid_i   = 1'b1;
        issue_req_i.rd  = stim_mem[b+1][4:0];
        issue_req_i.rs1 = stim_mem[b+2][4:0];
        issue_req_i.rs2 = stim_mem[b+3][4:0];
    endtask

    // Offer one instruction once the ROB has room, accepted at the next edge
    task automatic issue_instr(input int b);
        int waited;
        waited = 0;
        next_cycle();
        while (!issue_ready_o && waited < WAIT_LIMIT) begin
            next_cycle();
            waited++;
        end
        if (!issue_ready_o) begin
            report_timeout("issue_ready_o");
        end else begin
            drive_request(b);
            #1;                                   // Operands are combinational
            check_equal("issue_rob_idx_o", 32'(issue_rob_idx_o), stim_mem[b+4]);
            check_operand("rs1_op_o", rs1_op_o, stim_mem[b+5], stim_mem[b+6]);
            check_operand("rs2_op_o", rs2_op_o, stim_mem[b+7], stim_mem[b+8]);
        end
    endtask

    task automatic offer_when_full(input int b);
        next_cycle();
        drive_request(b);
        #1;
        check_equal("issue_ready_o", 32'(issue_ready_o), 32'd0);  // Must be refused
    endtask

    task automatic send_writeback(input int b);
        next_cycle();
        wb_valid_i  = 1'b1;
        wb_i.tag    = stim_mem[b+1][2:0];
        wb_i.data   = stim_mem[b+2];
    endtask

    // Commits are not back-pressured, so this cycle's head retires at the next edge
    task automatic expect_commit(input int b);
        int waited;
        waited = 0;
        next_cycle();
        while (!commit_valid_o && waited < WAIT_LIMIT) begin
            next_cycle();
            waited++;
        end
        if (!commit_valid_o) begin
            report_timeout("commit_valid_o");
        end else begin
            check_equal("commit_o.rd", 32'(commit_o.rd), stim_mem[b+1]);
            check_equal("commit_o.data", commit_o.data, stim_mem[b+2]);
        end
    endtask

    initial begin
        int b;
        checks        = 0;
        mismatches    = 0;
        aborts        = 0;
        cmd_no        = 0;
        rst_n_i       = 1'b0;
        flush_i       = 1'b0;
        issue_valid_i = 1'b0;
        issue_req_i   = '0;
        wb_valid_i    = 1'b0;
        wb_i          = '0;
        foreach (stim_mem[i]) begin
            stim_mem[i] = '0;                     // Unwritten lines read as end
        end
        $readmemh("test/rename_stim.txt", stim_mem);
        apply_reset();

        while (aborts == 0 && cmd_no < MAX_CMDS && stim_mem[cmd_no*COLS] != 0) begin
            b = cmd_no * COLS;
            case (stim_mem[b])
                32'd1: begin
                    next_cycle();
                    apply_reset();
                    #1;
                    check_status(b);
                end
                32'd2: issue_instr(b);
                32'd3: send_writeback(b);
                32'd4: expect_commit(b);
                32'd5: begin
                    next_cycle();
                    #1;
                    check_status(b);
                end
                32'd6: begin
                    next_cycle();
                    flush_i = 1'b1;
                end
                32'd7: offer_when_full(b);
                default: begin
                    aborts++;
                    $display("Unknown command code %0h at command %0d", stim_mem[b], cmd_no);
                end
            endcase
            cmd_no++;
        end
        next_cycle();                             // Let the last command take effect

        $display("Ran %0d commands: %0d checks, %0d mismatches, %0d aborts",
                 cmd_no, checks, mismatches, aborts);
        if (mismatches == 0 && aborts == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== hdl/rename_top.sv ====
// Register status and reorder stage of the out-of-order core
// Accepts one instruction per cycle on a valid/ready handshake, returns its ROB tag
// and both resolved source operands in the same cycle, takes writebacks in any
// order and reports in-order commits; flush empties the ROB and register status

`timescale 1ns/1ns
`default_nettype none

module rename_top (
    input  wire logic                clk_i,
    input  wire logic                rst_n_i,
    input  wire logic                flush_i,

    input  wire logic                issue_valid_i,
    input  wire isa_pkg::issue_req_t issue_req_i,
    output logic                     issue_ready_o,    // ROB not full
    output rob_pkg::rob_idx_t        issue_rob_idx_o,
    output rob_pkg::operand_t        rs1_op_o,
    output rob_pkg::operand_t        rs2_op_o,

    input  wire logic                wb_valid_i,
    input  wire rob_pkg::wb_t        wb_i,

    output logic                     commit_valid_o,
    output isa_pkg::commit_t         commit_o
);

    logic                    issue_accept;
    rob_pkg::regstat_entry_t rs1_stat, rs2_stat;
    rob_pkg::rob_idx_t       rob_tag1, rob_tag2;
    rob_pkg::rob_state_e     rob_state1, rob_state2;
    isa_pkg::word_t          rob_value1, rob_value2;
    isa_pkg::word_t          rf1, rf2;

    assign issue_accept = issue_valid_i & issue_ready_o;   // Handshake fires

    reg_status i_reg_status (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .flush_i     (flush_i),
        .issue_we_i  (issue_accept),
        .issue_rd_i  (issue_req_i.rd),
        .issue_tag_i (issue_rob_idx_o),
        .comm_we_i   (commit_valid_o),
        .comm_rd_i   (commit_o.rd),
        .rs1_idx_i   (issue_req_i.rs1),
        .rs2_idx_i   (issue_req_i.rs2),
        .rs1_stat_o  (rs1_stat),
        .rs2_stat_o  (rs2_stat)
    );

    reorder_buffer i_reorder_buffer (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .flush_i        (flush_i),
        .alloc_i        (issue_accept),
        .alloc_rd_i     (issue_req_i.rd),
        .ready_o        (issue_ready_o),
        .tail_o         (issue_rob_idx_o),
        .wb_valid_i     (wb_valid_i),
        .wb_i           (wb_i),
        .commit_valid_o (commit_valid_o),
        .commit_o       (commit_o),
        .tag1_i         (rob_tag1),
        .tag2_i         (rob_tag2),
        .state1_o       (rob_state1),
        .state2_o       (rob_state2),
        .value1_o       (rob_value1),
        .value2_o       (rob_value2)
    );

    arch_regfile i_arch_regfile (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .we_i    (commit_valid_o),
        .wr_i    (commit_o),
        .ra1_i   (issue_req_i.rs1),
        .ra2_i   (issue_req_i.rs2),
        .rd1_o   (rf1),
        .rd2_o   (rf2)
    );

    operand_select i_operand_select (
        .rs1_stat_i   (rs1_stat),
        .rs2_stat_i   (rs2_stat),
        .rob_state1_i (rob_state1),
        .rob_state2_i (rob_state2),
        .rob_value1_i (rob_value1),
        .rob_value2_i (rob_value2),
        .rf1_i        (rf1),
        .rf2_i        (rf2),
        .rob_tag1_o   (rob_tag1),
        .rob_tag2_o   (rob_tag2),
        .rs1_op_o     (rs1_op_o),
        .rs2_op_o     (rs2_op_o)
    );

endmodule

`default_nettype wire

// ==== hdl/operand_select.sv ====
// Source operand resolution for the issuing instruction
// Each operand comes from the register file when nothing is in flight,
// from the ROB when its youngest writer has finished, or else as a tag to wait on

`timescale 1ns/1ns
`default_nettype none

module operand_select (
    input  wire rob_pkg::regstat_entry_t rs1_stat_i,
    input  wire rob_pkg::regstat_entry_t rs2_stat_i,

    input  wire rob_pkg::rob_state_e     rob_state1_i,
    input  wire rob_pkg::rob_state_e     rob_state2_i,
    input  wire isa_pkg::word_t          rob_value1_i,
    input  wire isa_pkg::word_t          rob_value2_i,

    input  wire isa_pkg::word_t          rf1_i,
    input  wire isa_pkg::word_t          rf2_i,

    output rob_pkg::rob_idx_t            rob_tag1_o,   // ROB lookup for rs1
    output rob_pkg::rob_idx_t            rob_tag2_o,   // ROB lookup for rs2
    output rob_pkg::operand_t            rs1_op_o,
    output rob_pkg::operand_t            rs2_op_o
);

    function automatic rob_pkg::operand_t resolve(
        input rob_pkg::regstat_entry_t stat,
        input rob_pkg::rob_state_e     rob_state,
        input isa_pkg::word_t          rob_value,
        input isa_pkg::word_t          rf_value
    );
        rob_pkg::operand_t op;
        op.tag = stat.rob_idx;                      // Only looked at while not ready
        if (stat.busy == '0) begin
            op.ready = 1'b1;
            op.value = rf_value;                    // Architectural value is current
        end else if (rob_state == rob_pkg::ROB_DONE) begin
            op.ready = 1'b1;
            op.value = rob_value;                   // Forward finished result
        end else begin
            op.ready = 1'b0;
            op.value = '0;
        end
        return op;
    endfunction

    // The youngest writer is the one that matters
    assign rob_tag1_o = rs1_stat_i.rob_idx;
    assign rob_tag2_o = rs2_stat_i.rob_idx;

    assign rs1_op_o = resolve(rs1_stat_i, rob_state1_i, rob_value1_i, rf1_i);
    assign rs2_op_o = resolve(rs2_stat_i, rob_state2_i, rob_value2_i, rf2_i);

endmodule

`default_nettype wire

// ==== hdl/arch_regfile.sv ====
// Architectural register file
// Written only by retiring instructions, read combinationally by the issue stage
// Contents survive a flush; only reset clears them

`timescale 1ns/1ns
`default_nettype none

module arch_regfile (
    input  wire logic              clk_i,
    input  wire logic              rst_n_i,

    input  wire logic              we_i,     // Commit strobe
    input  wire isa_pkg::commit_t  wr_i,     // Register and value to write

    input  wire isa_pkg::reg_idx_t ra1_i,
    input  wire isa_pkg::reg_idx_t ra2_i,
    output isa_pkg::word_t         rd1_o,
    output isa_pkg::word_t         rd2_o
);

    isa_pkg::word_t regs_q [isa_pkg::REG_NUM];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            foreach (regs_q[i]) begin
                regs_q[i] <= '0;              // Known zeros after reset
            end
        end else if (we_i) begin
            regs_q[wr_i.rd] <= wr_i.data;     // r0 is writable like any other
        end
    end

    // No write-through, the issue stage sees the pre-edge value
    assign rd1_o = regs_q[ra1_i];
    assign rd2_o = regs_q[ra2_i];

endmodule

`default_nettype wire

// ==== hdl/reorder_buffer.sv ====
// Circular reorder buffer
// Entries are allocated at the tail in program order, completed out of order
// by writeback, and retired in order from the head into the register file
// Two tag read ports let the issue stage forward finished results

`timescale 1ns/1ns
`default_nettype none

module reorder_buffer (
    input  wire logic                 clk_i,
    input  wire logic                 rst_n_i,
    input  wire logic                 flush_i,

    // Allocation
    input  wire logic                 alloc_i,       // Accepted issue
    input  wire isa_pkg::reg_idx_t    alloc_rd_i,
    output logic                      ready_o,       // Room for one more
    output rob_pkg::rob_idx_t         tail_o,        // Tag the next issue receives

    // Writeback
    input  wire logic                 wb_valid_i,
    input  wire rob_pkg::wb_t         wb_i,

    // Commit
    output logic                      commit_valid_o,
    output isa_pkg::commit_t          commit_o,

    // Forwarding read ports
    input  wire rob_pkg::rob_idx_t    tag1_i,
    input  wire rob_pkg::rob_idx_t    tag2_i,
    output rob_pkg::rob_state_e       state1_o,
    output rob_pkg::rob_state_e       state2_o,
    output isa_pkg::word_t            value1_o,
    output isa_pkg::word_t            value2_o
);

    localparam int CNT_W = $clog2(rob_pkg::ROB_DEPTH) + 1;

    rob_pkg::rob_state_e  state_q [rob_pkg::ROB_DEPTH];
    isa_pkg::reg_idx_t    rd_q    [rob_pkg::ROB_DEPTH];  // Payload
    isa_pkg::word_t       value_q [rob_pkg::ROB_DEPTH];

    rob_pkg::rob_idx_t    head_q;
    rob_pkg::rob_idx_t    tail_q;
    logic [CNT_W-1:0]     count_q;                       // Occupied entries

    logic                 wb_hit;

    // Late or stray writebacks only land on pending entries
    assign wb_hit = wb_valid_i && (state_q[wb_i.tag] == rob_pkg::ROB_PENDING);

    // State and pointers
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            foreach (state_q[i]) begin
                state_q[i] <= rob_pkg::ROB_FREE;
            end
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else if (flush_i) begin
            foreach (state_q[i]) begin
                state_q[i] <= rob_pkg::ROB_FREE;
            end
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (alloc_i) begin
                state_q[tail_q] <= rob_pkg::ROB_PENDING;
                tail_q          <= tail_q + 1'b1;   // Wraps at ROB_DEPTH
            end
            if (wb_hit) begin
                state_q[wb_i.tag] <= rob_pkg::ROB_DONE;
            end
            if (commit_valid_o) begin
                state_q[head_q] <= rob_pkg::ROB_FREE;  // Head is never pending so wb cannot clash
                head_q          <= head_q + 1'b1;
            end

            case ({alloc_i, commit_valid_o})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;         // Neither or both at once
            endcase
        end
    end

    // Payload is meaningful only while the entry is allocated
    always_ff @(posedge clk_i) begin
        if (alloc_i) begin
            rd_q[tail_q] <= alloc_rd_i;
        end
        if (wb_hit) begin
            value_q[wb_i.tag] <= wb_i.data;
        end
    end

    assign ready_o = (count_q != CNT_W'(rob_pkg::ROB_DEPTH));
    assign tail_o  = tail_q;

    // A finished head retires every cycle unless a flush wins
    assign commit_valid_o = (state_q[head_q] == rob_pkg::ROB_DONE) && !flush_i;
    assign commit_o.rd    = rd_q[head_q];
    assign commit_o.data  = value_q[head_q];

    assign state1_o = state_q[tag1_i];
    assign state2_o = state_q[tag2_i];
    assign value1_o = value_q[tag1_i];
    assign value2_o = value_q[tag2_i];

endmodule

`default_nettype wire

// ==== hdl/reg_status.sv ====
// Register status table of the rename stage
// Per register it counts in-flight writers and remembers the youngest ROB tag
// Issue bumps the count, commit drops it; flush clears the whole table
// Two combinational lookup ports serve rs1 and rs2 of the issuing instruction

`timescale 1ns/1ns
`default_nettype none

module reg_status (
    input  wire logic                    clk_i,
    input  wire logic                    rst_n_i,
    input  wire logic                    flush_i,

    // Issue side, already qualified by the ROB handshake
    input  wire logic                    issue_we_i,
    input  wire isa_pkg::reg_idx_t       issue_rd_i,   // Destination of the issuing instr
    input  wire rob_pkg::rob_idx_t       issue_tag_i,  // ROB tail it was given

    // Commit side
    input  wire logic                    comm_we_i,
    input  wire isa_pkg::reg_idx_t       comm_rd_i,    // Destination of the retiring instr

    // Lookup ports
    input  wire isa_pkg::reg_idx_t       rs1_idx_i,
    input  wire isa_pkg::reg_idx_t       rs2_idx_i,
    output rob_pkg::regstat_entry_t      rs1_stat_o,
    output rob_pkg::regstat_entry_t      rs2_stat_o
);

    rob_pkg::regstat_entry_t stat_q [isa_pkg::REG_NUM];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            foreach (stat_q[i]) begin
                stat_q[i] <= '0;
            end
        end else if (flush_i) begin
            foreach (stat_q[i]) begin     // Nothing in flight after a flush
                stat_q[i] <= '0;
            end
        end else begin
            // Youngest writer always wins the tag
            if (issue_we_i) begin
                stat_q[issue_rd_i].rob_idx <= issue_tag_i;
            end

            for (int unsigned i = 0; i < isa_pkg::REG_NUM; i++) begin
                logic hit_issue;
                logic hit_comm;
                hit_issue = issue_we_i && (issue_rd_i == isa_pkg::reg_idx_t'(i));
                hit_comm  = comm_we_i && (comm_rd_i == isa_pkg::reg_idx_t'(i));
                if (hit_issue && !hit_comm) begin
                    stat_q[i].busy <= stat_q[i].busy + 1'b1;  // One more writer
                end else if (hit_comm && !hit_issue) begin
                    stat_q[i].busy <= stat_q[i].busy - 1'b1;  // Oldest writer retired
                end
                // Both on the same register cancel out
            end
        end
    end

    // Combinational lookups, state before the edge
    assign rs1_stat_o = stat_q[rs1_idx_i];
    assign rs2_stat_o = stat_q[rs2_idx_i];

endmodule

`default_nettype wire

// ==== hdl/rob_pkg.sv ====
// Reorder buffer definitions: depth, tags, entry states and the records
// exchanged between register status, ROB and operand resolution
// Builds on isa_pkg for register indexes and data words

`default_nettype none

package rob_pkg;

    localparam int ROB_DEPTH = 8;                    // Power of 2, pointers wrap freely

    typedef logic [$clog2(ROB_DEPTH)-1:0] rob_idx_t;  // 3-bit ROB tag
    typedef logic [$clog2(ROB_DEPTH):0]   busy_cnt_t; // 0 up to ROB_DEPTH writers

    typedef enum logic [1:0] {
        ROB_FREE    = 2'd0,  // Not allocated
        ROB_PENDING = 2'd1,  // Waiting for its result
        ROB_DONE    = 2'd2   // Result present, may retire
    } rob_state_e;

    // Status of one architectural register
    typedef struct packed {
        busy_cnt_t busy;     // In-flight writers
        rob_idx_t  rob_idx;  // Youngest writer
    } regstat_entry_t;

    typedef struct packed {
        rob_idx_t      tag;
        isa_pkg::word_t data;
    } wb_t;

    // Resolved source operand, tag only valid while not ready
    typedef struct packed {
        logic           ready;
        isa_pkg::word_t value;
        rob_idx_t       tag;
    } operand_t;

endpackage

`default_nettype wire

// ==== hdl/isa_pkg.sv ====
// Architectural definitions shared by the rename stage and its testbench
// Register file geometry, data word and the issue and commit records
// Used by the RTL blocks and the testbench alike

`default_nettype none

package isa_pkg;

    localparam int XLEN    = 32;                  // Data width
    localparam int REG_NUM = 32;                  // Architectural registers including r0

    typedef logic [$clog2(REG_NUM)-1:0] reg_idx_t; // 5-bit register index
    typedef logic [XLEN-1:0]            word_t;

    // Instruction entering the stage, in program order
    typedef struct packed {
        reg_idx_t rd;   // Destination
        reg_idx_t rs1;  // First source
        reg_idx_t rs2;  // Second source
    } issue_req_t;

    // Retired result headed for the register file
    typedef struct packed {
        reg_idx_t rd;
        word_t    data;
    } commit_t;

endpackage

`default_nettype wire
